// ==== flist.f ====
+incdir+design
design/scope_pkg.sv
design/symbol_source.sv
design/dds_wave_gen.sv
design/modulator_bank.sv
design/trace_formatter.sv
design/key_state_tracker.sv
design/modulation_scope_top.sv
verification/scope_monitor.sv
verification/tb_modulation_scope.sv

// ==== Bender.yml ====
package:
  name: modulation_scope

sources:
  - include_dirs:
      - design
    files:
      - design/scope_pkg.sv
      - design/symbol_source.sv
      - design/dds_wave_gen.sv
      - design/modulator_bank.sv
      - design/trace_formatter.sv
      - design/key_state_tracker.sv
      - design/modulation_scope_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/scope_monitor.sv
      - verification/tb_modulation_scope.sv

// ==== verification/tb_modulation_scope.sv ====
`timescale 1ns/1ps
`include "scope_macros.svh"

module tb_modulation_scope import scope_pkg::*;
();

   localparam int      N_TESTS      = 6;
   localparam int      TOP          = `PHASE_W - 1;
   localparam sample_t FULL_POS     = sample_t'(2047);
   localparam sample_t FULL_NEG     = sample_t'(-2048);
   localparam phase_t  QUARTER_TURN = phase_t'(1) << (`PHASE_W - 2);

   // key_1 first, same order as the flag struct
   localparam logic [7:0] MAKE_LIST [0:`KEY_COUNT-1] = '{`SC_MAKE_1, `SC_MAKE_2,
      `SC_MAKE_3, `SC_MAKE_4, `SC_MAKE_LEFT_ARROW, `SC_MAKE_RIGHT_ARROW,
      `SC_MAKE_UP_ARROW, `SC_MAKE_DOWN_ARROW};
   localparam logic [7:0] BREAK_LIST [0:`KEY_COUNT-1] = '{`SC_BREAK_1, `SC_BREAK_2,
      `SC_BREAK_3, `SC_BREAK_4, `SC_BREAK_LEFT_ARROW, `SC_BREAK_RIGHT_ARROW,
      `SC_BREAK_UP_ARROW, `SC_BREAK_DOWN_ARROW};

   typedef struct packed {
      mod_sel_e        mod_sel;
      wave_sel_e       wave_sel;
      phase_t          phase_inc;
      logic [15:0]     cycles;
      logic [2:0]      n_events;
      logic [0:3][7:0] events;   // from cycle 10, every 12 cycles
   } test_row_t;

   logic        CLK_25MHZ = 1'b0;
   logic        reset_from_key;
   kbd_event_t  kbd_event;
   scope_ctrl_t scope_ctrl;
   key_flags_t  key_flags;
   trace_t      trace;
   test_row_t   tests [N_TESTS];
   logic        tests_loaded = 1'b0;
   int          seed;
   int          trace_errors;
   int          key_errors;
   int          samples_seen;
   phase_t      m_phase;
   phase_t      m_ph1;
   phase_t      m_ph2;
   logic [4:0]  m_lfsr;
   logic [4:0]  m_lfsr_d;      // symbol seen by the modulators
   int          m_sym_cnt;
   int          m_dec_cnt;
   trace_t      exp_trace;
   key_flags_t  exp_flags;

   always #20 CLK_25MHZ = ~CLK_25MHZ;

   modulation_scope_top dut_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .kbd_event      (kbd_event),
      .scope_ctrl     (scope_ctrl),
      .key_flags      (key_flags),
      .trace          (trace)
   );

   scope_monitor monitor_i (.CLK_25MHZ, .trace, .exp_trace, .key_flags, .exp_flags,
                            .trace_errors, .key_errors, .samples_seen);

   // ====================
   // reference model
   // ====================
   function automatic sample_t sine_of(input phase_t ph);
      logic [`LUT_ADDR_W-1:0] idx;
      sample_t                mag;
      idx = ph[TOP-2 -: `LUT_ADDR_W];
      mag = ph[TOP-1] ? SINE_QUARTER[(1 << `LUT_ADDR_W) - 1 - idx] : SINE_QUARTER[idx];
      return ph[TOP] ? -mag : mag;   // second half turn negative
   endfunction

   function automatic sample_t wave_sample(input wave_sel_e sel, input phase_t ph);
      case (sel)
         SIN:     return sine_of(ph);
         COS:     return sine_of(ph + QUARTER_TURN);
         SAW:     return sample_t'({~ph[TOP], ph[TOP-1 -: `SAMPLE_W-1]});
         default: return ph[TOP] ? FULL_NEG : FULL_POS;
      endcase
   endfunction

   // symbol pair is lfsr bit 4 and bit 0
   function automatic sample_t mod_sample(input mod_sel_e sel, input phase_t ph,
                                          input logic [4:0] lfsr);
      sample_t s;
      sample_t c;
      s = sine_of(ph);
      c = sine_of(ph + QUARTER_TURN);
      case (sel)
         ASK:     return lfsr[0] ? s : sample_t'(0);
         BPSK:    return lfsr[0] ? s : ~s;
         LFSR:    return lfsr[0] ? FULL_POS : FULL_NEG;
         QPSK:    return lfsr[4] ? (lfsr[0] ? ~s : ~c) : (lfsr[0] ? c : s);
         default: return s;
      endcase
   endfunction

   function automatic logic [`TRACE_W-1:0] plot_byte(input sample_t s);
      return {~s[`SAMPLE_W-1], s[`SAMPLE_W-2 -: `TRACE_W-1]};
   endfunction

   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         m_phase         <= '0;
         m_ph1           <= '0;
         m_ph2           <= '0;
         m_lfsr          <= `LFSR_SEED;
         m_lfsr_d        <= `LFSR_SEED;
         m_sym_cnt       <= 0;
         m_dec_cnt       <= 0;
         exp_trace.valid <= 1'b0;
         exp_flags       <= '0;
      end
      else
      begin
         m_phase   <= m_phase + scope_ctrl.phase_inc;
         m_ph1     <= m_phase;
         m_ph2     <= m_ph1;    // phase behind the sample taken now
         m_lfsr_d  <= m_lfsr;
         m_sym_cnt <= (m_sym_cnt == `SYMBOL_DIV - 1) ? 0 : m_sym_cnt + 1;
         if (m_sym_cnt == `SYMBOL_DIV - 1)
            m_lfsr <= {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
         m_dec_cnt       <= (m_dec_cnt == `TRACE_DIV - 1) ? 0 : m_dec_cnt + 1;
         exp_trace.valid <= (m_dec_cnt == `TRACE_DIV - 1);
         if (m_dec_cnt == `TRACE_DIV - 1)
         begin
            exp_trace.modulated <= plot_byte(mod_sample(scope_ctrl.mod_sel, m_ph2, m_lfsr_d));
            exp_trace.plain     <= plot_byte(wave_sample(scope_ctrl.wave_sel, m_ph2));
         end
         if (kbd_event.strobe)
         begin
            for (int i = 0; i < `KEY_COUNT; i++)
            begin
               if (kbd_event.code == MAKE_LIST[i])
                  exp_flags[`KEY_COUNT-1-i] <= 1'b1;
               else if (kbd_event.code == BREAK_LIST[i])
                  exp_flags[`KEY_COUNT-1-i] <= 1'b0;
            end
         end
      end
   end

   // ====================
   // stimulus
   // ====================
   // table events on their slots, random filler elsewhere
   task automatic drive_key_event(input int t, input int c);
      int slot;
      slot = (c - 10) / 12;
      if (c >= 10 && (c - 10) % 12 == 0 && slot < tests[t].n_events)
         kbd_event = '{strobe: 1'b1, code: tests[t].events[slot]};
      else
         kbd_event = '{strobe: (c % 5 == 3), code: 8'($random(seed))};
   endtask

   initial
   begin
      seed           = 93523;
      reset_from_key = 1'b1;
      kbd_event      = '0;
      scope_ctrl     = '0;
      // mod_sel, wave_sel, phase_inc, cycles, events used, events
      tests[0] = '{SINE, SIN, 32'h0400_0000, 16'd200, 3'd4,
                   {`SC_MAKE_1, `SC_MAKE_UP_ARROW, `SC_BREAK_1, 8'h5A}};
      tests[1] = '{ASK, COS, 32'h0400_0000, 16'd400, 3'd4,
                   {`SC_MAKE_2, `SC_MAKE_LEFT_ARROW, `SC_BREAK_UP_ARROW, `SC_MAKE_DOWN_ARROW}};
      tests[2] = '{BPSK, SAW, 32'h0400_0000, 16'd400, 3'd4,
                   {`SC_MAKE_3, `SC_MAKE_4, `SC_BREAK_2, `SC_MAKE_RIGHT_ARROW}};
      tests[3] = '{LFSR, SQU, 32'h0400_0000, 16'd700, 3'd4,
                   {`SC_BREAK_LEFT_ARROW, `SC_BREAK_DOWN_ARROW, `SC_BREAK_3, 8'hE0}};
      tests[4] = '{QPSK, SIN, 32'h0400_0000, 16'd700, 3'd3,
                   {`SC_BREAK_4, `SC_BREAK_RIGHT_ARROW, `SC_MAKE_1, 8'h00}};
      tests[5] = '{QPSK, COS, 32'h0123_4567, 16'd400, 3'd2,
                   {`SC_BREAK_1, `SC_MAKE_UP_ARROW, 8'h00, 8'h00}};
      tests_loaded = 1'b1;
      repeat (16) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;
      for (int t = 0; t < N_TESTS; t++)
      begin
         scope_ctrl = '{mod_sel: tests[t].mod_sel, wave_sel: tests[t].wave_sel,
                        phase_inc: tests[t].phase_inc};
         for (int c = 0; c < tests[t].cycles; c++)
         begin
            drive_key_event(t, c);
            @(posedge CLK_25MHZ);
            #2;
         end
      end
      kbd_event = '0;
      repeat (8) @(posedge CLK_25MHZ);
      @(negedge CLK_25MHZ);
      #1;
      if (samples_seen == 0)
         $display("no trace samples were compared");
      $display("errors: trace %0d, key_flags %0d (%0d samples compared)",
               trace_errors, key_errors, samples_seen);
      if (trace_errors == 0 && key_errors == 0 && samples_seen > 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   // watchdog at 1.5 times the table length
   initial
   begin
      longint limit_ns;
      wait (tests_loaded);
      limit_ns = 0;
      for (int t = 0; t < N_TESTS; t++)
         limit_ns += tests[t].cycles;
      limit_ns = limit_ns * 3 / 2 * 40;
      #(limit_ns);
      $display("timeout: the run did not finish within %0d ns", limit_ns);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== verification/scope_monitor.sv ====
`timescale 1ns/1ps

module scope_monitor import scope_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  trace_t     trace,
   input  trace_t     exp_trace,
   input  key_flags_t key_flags,
   input  key_flags_t exp_flags,
   output int         trace_errors,
   output int         key_errors,
   output int         samples_seen
);

   logic started = 1'b0;

   // one line per mismatch, x and z count as wrong
   function automatic int mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
      if (actual === expected)
         return 0;
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      return 1;
   endfunction

   initial
   begin
      trace_errors = 0;
      key_errors   = 0;
      samples_seen = 0;
   end

   always @(posedge CLK_25MHZ)
      started <= 1'b1;   // registers hold reset values from here

   // ====================
   // compare mid-cycle
   // ====================
   always @(negedge CLK_25MHZ)
   begin
      if (started)
      begin
         trace_errors += mismatch("trace.valid", 8'(exp_trace.valid), 8'(trace.valid));
         key_errors   += mismatch("key_flags", exp_flags, key_flags);
         if (exp_trace.valid)
         begin
            samples_seen++;
            trace_errors += mismatch("trace.modulated", exp_trace.modulated,
                                     trace.modulated);
            trace_errors += mismatch("trace.plain", exp_trace.plain, trace.plain);
         end
      end
   end

endmodule

// ==== design/modulation_scope_top.sv ====
`timescale 1ns/1ps

module modulation_scope_top import scope_pkg::*;
(
   input  logic        CLK_25MHZ,
   input  logic        reset_from_key,
   input  kbd_event_t  kbd_event,
   input  scope_ctrl_t scope_ctrl,
   output key_flags_t  key_flags,
   output trace_t      trace
);

   symbol_t   symbol;
   wave_set_t waves;
   wave_set_t waves_d;     // plain path, one cycle behind
   mod_set_t  mods;

   // ====================
   // modulation pipeline
   // ====================
   symbol_source symbol_source_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .symbol         (symbol)
   );

   dds_wave_gen dds_wave_gen_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (scope_ctrl.phase_inc),
      .waves          (waves),
      .waves_d        (waves_d)
   );

   modulator_bank modulator_bank_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .waves          (waves),
      .symbol         (symbol),
      .mods           (mods)
   );

   trace_formatter trace_formatter_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mods           (mods),
      .waves_d        (waves_d),
      .mod_sel        (scope_ctrl.mod_sel),
      .wave_sel       (scope_ctrl.wave_sel),
      .trace          (trace)
   );

   // keyboard branch, independent of the scope path
   key_state_tracker key_state_tracker_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .kbd_event      (kbd_event),
      .key_flags      (key_flags)
   );

endmodule

// ==== design/key_state_tracker.sv ====
`timescale 1ns/1ps
`include "scope_macros.svh"

module key_state_tracker import scope_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   input  kbd_event_t kbd_event,
   output key_flags_t key_flags
);

   // msb first, same order as key_flags_t
   localparam logic [7:0] MAKE_CODES [`KEY_COUNT-1:0] = '{
      `SC_MAKE_1, `SC_MAKE_2, `SC_MAKE_3, `SC_MAKE_4,
      `SC_MAKE_LEFT_ARROW, `SC_MAKE_RIGHT_ARROW,
      `SC_MAKE_UP_ARROW, `SC_MAKE_DOWN_ARROW
   };
   localparam logic [7:0] BREAK_CODES [`KEY_COUNT-1:0] = '{
      `SC_BREAK_1, `SC_BREAK_2, `SC_BREAK_3, `SC_BREAK_4,
      `SC_BREAK_LEFT_ARROW, `SC_BREAK_RIGHT_ARROW,
      `SC_BREAK_UP_ARROW, `SC_BREAK_DOWN_ARROW
   };

   logic [`KEY_COUNT-1:0] held;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held <= '0;
      end
      else if (kbd_event.strobe)
      begin
         for (int i = 0; i < `KEY_COUNT; i++)
         begin
            if (kbd_event.code == MAKE_CODES[i])
               held[i] <= 1'b1;
            else if (kbd_event.code == BREAK_CODES[i])
               held[i] <= 1'b0;
         end
      end
   end

   assign key_flags = held;

   a_flags_hold: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !kbd_event.strobe |=> $stable(key_flags));

endmodule

// ==== design/trace_formatter.sv ====
`timescale 1ns/1ps
`include "scope_macros.svh"

module trace_formatter import scope_pkg::*;
#(
   parameter int TRACE_DIV = `TRACE_DIV
)
(
   input  logic      CLK_25MHZ,
   input  logic      reset_from_key,
   input  mod_set_t  mods,
   input  wave_set_t waves_d,
   input  mod_sel_e  mod_sel,
   input  wave_sel_e wave_sel,
   output trace_t    trace
);

   localparam int CNT_W = (TRACE_DIV > 1) ? $clog2(TRACE_DIV) : 1;

   logic [CNT_W-1:0]    dec_count;
   logic                take;
   logic                valid_q;
   logic [`TRACE_W-1:0] mod_q;
   logic [`TRACE_W-1:0] plain_q;
   sample_t             mod_pick;
   sample_t             plain_pick;

   // top bits to offset binary
   function automatic logic [`TRACE_W-1:0] to_plot(input sample_t s);
      return {~s[`SAMPLE_W-1], s[`SAMPLE_W-2 -: `TRACE_W-1]};
   endfunction

   always_comb
   begin
      case (mod_sel)
         ASK:     mod_pick = mods.ask;
         BPSK:    mod_pick = mods.bpsk;
         LFSR:    mod_pick = mods.lfsr;
         QPSK:    mod_pick = mods.qpsk;
         default: mod_pick = mods.sine;
      endcase
      case (wave_sel)
         SIN:     plain_pick = waves_d.sin;
         COS:     plain_pick = waves_d.cos;
         SAW:     plain_pick = waves_d.saw;
         default: plain_pick = waves_d.squ;
      endcase
   end

   // ====================
   // decimation
   // ====================
   assign take = (dec_count == CNT_W'(TRACE_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         dec_count <= '0;
         valid_q   <= 1'b0;
      end
      else
      begin
         dec_count <= take ? '0 : dec_count + 1'b1;
         valid_q   <= take;
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (take)
      begin
         mod_q   <= to_plot(mod_pick);
         plain_q <= to_plot(plain_pick);   // held until next strobe
      end
   end

   assign trace = '{valid: valid_q, modulated: mod_q, plain: plain_q};

   a_valid_single: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (TRACE_DIV > 1) && trace.valid |=> !trace.valid);

endmodule

// ==== design/modulator_bank.sv ====
`timescale 1ns/1ps
`include "scope_macros.svh"

module modulator_bank import scope_pkg::*;
(
   input  logic      CLK_25MHZ,
   input  logic      reset_from_key,
   input  wave_set_t waves,
   input  symbol_t   symbol,
   output mod_set_t  mods
);

   sample_t qpsk_next;

   // ====================
   // qpsk constellation
   // ====================
   always_comb
   begin
      case ({symbol.b1, symbol.b0})
         2'b00:   qpsk_next = waves.sin;
         2'b01:   qpsk_next = waves.cos;
         2'b11:   qpsk_next = ~waves.sin;
         default: qpsk_next = ~waves.cos;   // 10
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         mods <= '0;
      end
      else
      begin
         mods.ask  <= symbol.b0 ? waves.sin : sample_t'(0);   // on/off keying
         mods.sine <= waves.sin;                              // unmodulated carrier
         mods.bpsk <= symbol.b0 ? waves.sin : ~waves.sin;
         mods.lfsr <= symbol.b0 ? SAMPLE_MAX : SAMPLE_MIN;
         mods.qpsk <= qpsk_next;
      end
   end

endmodule

// ==== design/dds_wave_gen.sv ====
`timescale 1ns/1ps
`include "scope_macros.svh"

module dds_wave_gen import scope_pkg::*;
(
   input  logic      CLK_25MHZ,
   input  logic      reset_from_key,
   input  phase_t    phase_inc,
   output wave_set_t waves,
   output wave_set_t waves_d
);

   localparam int ADDR_W = `LUT_ADDR_W + 2;   // quadrant + table index

   phase_t            phase;
   logic [ADDR_W-1:0] sin_addr;
   logic [ADDR_W-1:0] cos_addr;
   wave_set_t         waves_next;

   // ====================
   // phase accumulator
   // ====================
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + phase_inc;
   end

   // quarter-wave table unfolded over four quadrants
   function automatic sample_t wave_lookup(input logic [ADDR_W-1:0] addr);
      logic [1:0]             quad;
      logic [`LUT_ADDR_W-1:0] idx;
      quad = addr[ADDR_W-1 -: 2];
      idx  = addr[`LUT_ADDR_W-1:0];
      case (quad)
         2'd0:    return SINE_QUARTER[idx];
         2'd1:    return SINE_QUARTER[~idx];    // mirrored
         2'd2:    return -SINE_QUARTER[idx];
         default: return -SINE_QUARTER[~idx];
      endcase
   endfunction

   assign sin_addr = phase[`PHASE_W-1 -: ADDR_W];
   assign cos_addr = sin_addr + ADDR_W'(1 << `LUT_ADDR_W);   // quarter turn ahead

   always_comb
   begin
      waves_next.sin = wave_lookup(sin_addr);
      waves_next.cos = wave_lookup(cos_addr);
      waves_next.squ = phase[`PHASE_W-1] ? SAMPLE_MIN : SAMPLE_MAX;
      // top bits, msb flipped to make it signed
      waves_next.saw = {~phase[`PHASE_W-1], phase[`PHASE_W-2 -: `SAMPLE_W-1]};
   end

   // ====================
   // output registers
   // ====================
   always_ff @(posedge CLK_25MHZ)
   begin
      waves   <= waves_next;
      waves_d <= waves;     // lines up with the modulator stage
   end

endmodule

// ==== design/symbol_source.sv ====
`timescale 1ns/1ps
`include "scope_macros.svh"

module symbol_source import scope_pkg::*;
#(
   parameter int SYMBOL_DIV = `SYMBOL_DIV
)
(
   input  logic    CLK_25MHZ,
   input  logic    reset_from_key,
   output symbol_t symbol
);

   localparam int         CNT_W     = (SYMBOL_DIV > 1) ? $clog2(SYMBOL_DIV) : 1;
   localparam logic [4:0] LFSR_INIT = `LFSR_SEED;

   logic [CNT_W-1:0] div_count;
   logic             sym_strobe;
   logic [4:0]       lfsr;
   logic [4:0]       lfsr_next;

   assign sym_strobe = (div_count == CNT_W'(SYMBOL_DIV - 1));
   assign lfsr_next  = {lfsr[3:0], lfsr[4] ^ lfsr[2]};   // taps 4 and 2

   // ====================
   // symbol rate divider
   // ====================
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         div_count <= '0;
      else if (sym_strobe)
         div_count <= '0;
      else
         div_count <= div_count + 1'b1;
   end

   // lfsr and symbol move together
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr   <= LFSR_INIT;
         symbol <= '{b1: LFSR_INIT[4], b0: LFSR_INIT[0]};
      end
      else if (sym_strobe)
      begin
         lfsr   <= lfsr_next;
         symbol <= '{b1: lfsr_next[4], b0: lfsr_next[0]};   // new bits, same edge
      end
   end

   // all-zero state would lock up
   a_lfsr_nonzero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr != '0);

   a_symbol_on_strobe: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !$stable(symbol) |-> $past(sym_strobe));

endmodule

// ==== design/scope_pkg.sv ====
`include "scope_macros.svh"

package scope_pkg;

   typedef logic signed [`SAMPLE_W-1:0] sample_t;
   typedef logic [`PHASE_W-1:0] phase_t;

   // full scale levels
   localparam sample_t SAMPLE_MAX = sample_t'((1 << (`SAMPLE_W-1)) - 1);   // +2047
   localparam sample_t SAMPLE_MIN = sample_t'(1 << (`SAMPLE_W-1));         // -2048

   typedef struct packed {
      sample_t sin;
      sample_t cos;
      sample_t squ;
      sample_t saw;
   } wave_set_t;

   typedef struct packed {
      sample_t ask;
      sample_t sine;
      sample_t bpsk;
      sample_t lfsr;
      sample_t qpsk;
   } mod_set_t;

   typedef struct packed {
      logic b1;   // lfsr bit 4
      logic b0;   // lfsr bit 0
   } symbol_t;

   typedef enum logic [2:0] {ASK, SINE, BPSK, LFSR, QPSK} mod_sel_e;
   typedef enum logic [1:0] {SIN, COS, SAW, SQU} wave_sel_e;

   typedef struct packed {
      mod_sel_e  mod_sel;
      wave_sel_e wave_sel;
      phase_t    phase_inc;
   } scope_ctrl_t;

   typedef struct packed {
      logic       strobe;
      logic [7:0] code;
   } kbd_event_t;

   typedef struct packed {
      logic key_1;
      logic key_2;
      logic key_3;
      logic key_4;
      logic left;
      logic right;
      logic up;
      logic down;
   } key_flags_t;

   typedef struct packed {
      logic                valid;
      logic [`TRACE_W-1:0] modulated;
      logic [`TRACE_W-1:0] plain;
   } trace_t;

   // sine at bin centres of the first quadrant
   localparam sample_t SINE_QUARTER [0:(1 << `LUT_ADDR_W)-1] = '{
      12'sd100,  12'sd300,  12'sd497,  12'sd690,
      12'sd875,  12'sd1052, 12'sd1219, 12'sd1375,
      12'sd1517, 12'sd1644, 12'sd1756, 12'sd1850,
      12'sd1927, 12'sd1986, 12'sd2025, 12'sd2045
   };

endpackage

// ==== design/scope_macros.svh ====
`ifndef SCOPE_MACROS_SVH
`define SCOPE_MACROS_SVH

// ====================
// datapath widths
// ====================
`define SAMPLE_W      12        // waveform sample, signed
`define PHASE_W       32        // phase accumulator
`define LUT_ADDR_W    4         // quarter-wave table index, 16 entries
`define TRACE_W       8         // plot sample, offset binary

// ====================
// rates and seeds
// ====================
`define SYMBOL_DIV    64        // clocks per symbol
`define TRACE_DIV     4         // clocks per plot sample
`define LFSR_SEED     5'b00001

// ====================
// keyboard events
// ====================
`define KEY_COUNT     8

// make codes follow the set 2 scan codes
`define SC_MAKE_1             8'h16
`define SC_MAKE_2             8'h1E
`define SC_MAKE_3             8'h26
`define SC_MAKE_4             8'h25
`define SC_MAKE_LEFT_ARROW    8'h6B
`define SC_MAKE_RIGHT_ARROW   8'h74
`define SC_MAKE_UP_ARROW      8'h75
`define SC_MAKE_DOWN_ARROW    8'h72

// break = make with bit 7 set
`define SC_BREAK_1            8'h96
`define SC_BREAK_2            8'h9E
`define SC_BREAK_3            8'hA6
`define SC_BREAK_4            8'hA5
`define SC_BREAK_LEFT_ARROW   8'hEB
`define SC_BREAK_RIGHT_ARROW  8'hF4
`define SC_BREAK_UP_ARROW     8'hF5
`define SC_BREAK_DOWN_ARROW   8'hF2

`endif
